/* verilog/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

	typedef enum logic [2:0] {
		op_nop   = 3'd0,
		op_add   = 3'd1,
		op_sub   = 3'd2,
		op_mul   = 3'd3,
		op_madd  = 3'd4,
		op_msub  = 3'd5,
		op_nmsub = 3'd6,
		op_nmadd = 3'd7
	} fp_op_t;

	// Codes other than rtz round to nearest even
	typedef logic [2:0] fp_rm_t;

	localparam fp_rm_t rm_rne = 3'b000;
	localparam fp_rm_t rm_rtz = 3'b001;

	typedef struct packed {
		logic iv;
		logic of;
		logic uf;
		logic ie;
	} fp_flags_t;

	typedef struct packed {
		fp_op_t      op;
		fp_rm_t      rm;
		logic [31:0] a;
		logic [31:0] b;
	} fp_req_t;

	typedef struct packed {
		logic [31:0] result;
		fp_flags_t   flags;
	} fp_resp_t;

	localparam logic [31:0] fp_canon_nan = 32'h7fc0_0000;

endpackage

`default_nettype wire

/* verilog/fp_stage_reg.sv */
`default_nettype none

module fp_stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     flush,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     full;
	payload_t data_q;

	// Accept when empty or when the held entry leaves this cycle
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			full <= 1'b0;
		else if (flush)
			full <= 1'b0;
		else if (in_valid && in_ready)
			full <= 1'b1;
		else if (out_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			data_q <= in_data;
	end

endmodule

`default_nettype wire

/* verilog/fp_addsub.sv */
`default_nettype none

module fp_addsub (
	input  logic               sub,
	input  fpu_pkg::fp_rm_t    rm,
	input  logic [31:0]        a,
	input  logic [31:0]        b,
	output logic [31:0]        y,
	output fpu_pkg::fp_flags_t flags
);
	import fpu_pkg::*;

	logic              sa, sb;
	logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
	logic [23:0]       ma, mb;
	logic              swap;
	logic              s_big;
	logic [7:0]        e_big, e_diff;
	logic [23:0]       m_big, m_small;
	logic [49:0]       shifted;
	logic [26:0]       aligned;
	logic [27:0]       sum;
	logic [4:0]        lz;
	logic [26:0]       norm;
	logic signed [9:0] exp_n, exp_r;
	logic              guard, rest, round_up;
	logic [24:0]       mant_r;

	assign sa     = a[31];
	assign sb     = b[31] ^ sub;
	// Subnormals read as zero
	assign a_zero = (a[30:23] == 8'd0);
	assign b_zero = (b[30:23] == 8'd0);
	assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
	assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
	assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
	assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
	assign ma     = a_zero ? 24'd0 : {1'b1, a[22:0]};
	assign mb     = b_zero ? 24'd0 : {1'b1, b[22:0]};

	// Larger magnitude goes first so the difference never goes negative
	assign swap    = {b[30:23], mb} > {a[30:23], ma};
	assign s_big   = swap ? sb : sa;
	assign e_big   = swap ? b[30:23] : a[30:23];
	assign e_diff  = swap ? b[30:23] - a[30:23] : a[30:23] - b[30:23];
	assign m_big   = swap ? mb : ma;
	assign m_small = swap ? ma : mb;

	// Guard, round, then everything below folded into sticky
	assign shifted = {m_small, 26'd0} >> ((e_diff > 8'd31) ? 5'd31 : e_diff[4:0]);
	assign aligned = {shifted[49:24], |shifted[23:0]};
	assign sum     = (sa != sb) ? {1'b0, m_big, 3'd0} - {1'b0, aligned}
	                            : {1'b0, m_big, 3'd0} + {1'b0, aligned};

	always_comb begin
		lz = 5'd0;
		for (int i = 0; i < 27; i++) begin
			if (sum[i])
				lz = 5'(26 - i);
		end
	end

	assign norm  = sum[27] ? {sum[27:2], sum[1] | sum[0]} : sum[26:0] << lz;
	assign exp_n = sum[27] ? $signed({2'b00, e_big}) + 10'sd1
	                       : $signed({2'b00, e_big}) - $signed({5'd0, lz});

	assign guard    = norm[2];
	assign rest     = norm[1] | norm[0];
	assign round_up = (rm != rm_rtz) && guard && (rest || norm[3]);
	assign mant_r   = {1'b0, norm[26:3]} + {24'd0, round_up};
	assign exp_r    = mant_r[24] ? exp_n + 10'sd1 : exp_n;

	always_comb begin
		flags = '0;
		if (a_nan || b_nan) begin
			y        = fp_canon_nan;
			flags.iv = (a_nan && !a[22]) || (b_nan && !b[22]);
		end else if (a_inf && b_inf && (sa != sb)) begin
			y        = fp_canon_nan;
			flags.iv = 1'b1;
		end else if (a_inf) begin
			y = {sa, 8'hff, 23'd0};
		end else if (b_inf) begin
			y = {sb, 8'hff, 23'd0};
		end else if (sum == 28'd0) begin
			y = {sa & sb, 31'd0};
		end else if (exp_n < 10'sd1) begin
			y        = {s_big, 31'd0};
			flags.uf = 1'b1;
			flags.ie = 1'b1;
		end else if (exp_r > 10'sd254) begin
			y        = (rm == rm_rtz) ? {s_big, 8'hfe, 23'h7fffff} : {s_big, 8'hff, 23'd0};
			flags.of = 1'b1;
			flags.ie = 1'b1;
		end else begin
			y        = {s_big, exp_r[7:0], mant_r[22:0]};
			flags.ie = guard || rest;
		end
	end

endmodule

`default_nettype wire

/* verilog/fp_mul.sv */
`default_nettype none

module fp_mul (
	input  fpu_pkg::fp_rm_t    rm,
	input  logic [31:0]        a,
	input  logic [31:0]        b,
	output logic [31:0]        y,
	output fpu_pkg::fp_flags_t flags
);
	import fpu_pkg::*;

	logic              s;
	logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
	logic [47:0]       prod;
	logic [23:0]       mant;
	logic              guard, rest, round_up;
	logic [24:0]       mant_r;
	logic signed [9:0] exp_n, exp_r;

	assign s      = a[31] ^ b[31];
	assign a_zero = (a[30:23] == 8'd0);
	assign b_zero = (b[30:23] == 8'd0);
	assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
	assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
	assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
	assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);

	assign prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};

	// Product lies in [1,4), so at most one position of normalization
	assign mant  = prod[47] ? prod[47:24] : prod[46:23];
	assign guard = prod[47] ? prod[23] : prod[22];
	assign rest  = prod[47] ? |prod[22:0] : |prod[21:0];
	assign exp_n = $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127
	               + (prod[47] ? 10'sd1 : 10'sd0);

	assign round_up = (rm != rm_rtz) && guard && (rest || mant[0]);
	assign mant_r   = {1'b0, mant} + {24'd0, round_up};
	assign exp_r    = mant_r[24] ? exp_n + 10'sd1 : exp_n;

	always_comb begin
		flags = '0;
		if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
			y        = fp_canon_nan;
			flags.iv = 1'b1;
		end else if (a_inf || b_inf) begin
			y = {s, 8'hff, 23'd0};
		end else if (a_zero || b_zero) begin
			y = {s, 31'd0};
		end else if (exp_n < 10'sd1) begin
			// Too small for a normal, flushed
			y        = {s, 31'd0};
			flags.uf = 1'b1;
			flags.ie = 1'b1;
		end else if (exp_r > 10'sd254) begin
			y        = (rm == rm_rtz) ? {s, 8'hfe, 23'h7fffff} : {s, 8'hff, 23'd0};
			flags.of = 1'b1;
			flags.ie = 1'b1;
		end else begin
			y        = {s, exp_r[7:0], mant_r[22:0]};
			flags.ie = guard || rest;
		end
	end

endmodule

`default_nettype wire

/* verilog/fpu_core.sv */
`default_nettype none

module fpu_core (
	input  logic              clk,
	input  logic              reset,
	input  logic              flush,
	input  logic              core_valid,
	output logic              core_ready,
	input  fpu_pkg::fp_req_t  core_req,
	output logic              resp_valid,
	input  logic              resp_ready,
	output fpu_pkg::fp_resp_t resp
);
	import fpu_pkg::*;

	logic        req_valid;
	logic        req_ready;
	fp_req_t     req_q;
	logic [31:0] add_y;
	fp_flags_t   add_flags;
	logic [31:0] mul_y;
	fp_flags_t   mul_flags;
	fp_resp_t    calc;

	fp_stage_reg #(
		.payload_t(fp_req_t)
	) req_stage (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.in_valid  (core_valid),
		.in_ready  (core_ready),
		.in_data   (core_req),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req_q)
	);

	fp_addsub u_addsub (
		.sub   (req_q.op == op_sub),
		.rm    (req_q.rm),
		.a     (req_q.a),
		.b     (req_q.b),
		.y     (add_y),
		.flags (add_flags)
	);

	fp_mul u_mul (
		.rm    (req_q.rm),
		.a     (req_q.a),
		.b     (req_q.b),
		.y     (mul_y),
		.flags (mul_flags)
	);

	always_comb begin
		if (req_q.op == op_mul)
			calc = '{result: mul_y, flags: mul_flags};
		else
			calc = '{result: add_y, flags: add_flags};
	end

	fp_stage_reg #(
		.payload_t(fp_resp_t)
	) resp_stage (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (calc),
		.out_valid (resp_valid),
		.out_ready (resp_ready),
		.out_data  (resp)
	);

endmodule

`default_nettype wire

/* verilog/fpu.sv */
`default_nettype none

module fpu (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               valid_in,
	output logic               ready_out,
	input  fpu_pkg::fp_op_t    op,
	input  fpu_pkg::fp_rm_t    rm,
	input  logic [31:0]        a,
	input  logic [31:0]        b,
	input  logic [31:0]        c,
	output logic               valid_out,
	input  logic               ready_in,
	output logic [31:0]        result,
	output fpu_pkg::fp_flags_t flags
);
	import fpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_first,
		st_second,
		st_done
	} state_t;

	state_t      state;
	fp_op_t      op_q;
	fp_rm_t      rm_q;
	logic [31:0] c_q;
	fp_flags_t   first_flags;
	logic        core_valid;
	logic        core_ready;
	fp_req_t     core_req;
	logic        resp_valid;
	logic        resp_ready;
	fp_resp_t    resp;
	logic        fused_in;
	logic        negate;

	assign fused_in = (op == op_madd) || (op == op_msub) || (op == op_nmsub) || (op == op_nmadd);
	assign negate   = (op_q == op_nmsub) || (op_q == op_nmadd);

	assign ready_out = (state == st_idle);
	// The product of a fused op is consumed here and never reaches the output
	assign resp_ready = (state == st_first) || ready_in;
	assign valid_out  = resp_valid && ((state == st_second) || (state == st_done)) && !flush;
	assign result     = resp.result;
	assign flags      = resp.flags | first_flags;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state      <= st_idle;
			core_valid <= 1'b0;
		end else if (flush) begin
			state      <= st_idle;
			core_valid <= 1'b0;
		end else begin
			if (core_valid && core_ready)
				core_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (valid_in) begin
						state      <= fused_in ? st_first : st_second;
						core_valid <= 1'b1;
					end
				end
				st_first: begin
					if (resp_valid) begin
						state      <= st_second;
						core_valid <= 1'b1;
					end
				end
				st_second: begin
					if (resp_valid)
						state <= ready_in ? st_idle : st_done;
				end
				st_done: begin
					if (ready_in)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			op_q        <= op;
			rm_q        <= rm;
			c_q         <= c;
			first_flags <= '0;
			core_req.op <= fused_in ? op_mul : op;
			core_req.rm <= rm;
			core_req.a  <= a;
			core_req.b  <= b;
		end else if ((state == st_first) && resp_valid) begin
			// Second pass adds or subtracts c from the returned product
			first_flags <= resp.flags;
			core_req.op <= ((op_q == op_madd) || (op_q == op_nmsub)) ? op_add : op_sub;
			core_req.rm <= rm_q;
			core_req.a  <= {resp.result[31] ^ negate, resp.result[30:0]};
			core_req.b  <= c_q;
		end
	end

	fpu_core u_core (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.core_valid (core_valid),
		.core_ready (core_ready),
		.core_req   (core_req),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

endmodule

`default_nettype wire

/* tests/fpu_properties.sv */
`default_nettype none

module fpu_properties (
	input wire logic               clk,
	input wire logic               reset,
	input wire logic               flush,
	input wire logic               valid_in,
	input wire logic               ready_out,
	input wire logic               valid_out,
	input wire logic               ready_in,
	input wire logic [31:0]        result,
	input wire fpu_pkg::fp_flags_t flags
);
	timeunit 1ns;
	timeprecision 1ps;

	// Idle outputs while reset is held
	reset_idle: assert property (@(posedge clk) reset |-> !valid_out && ready_out)
		else $error("valid_out or ready_out wrong during reset");

	valid_held: assert property (@(posedge clk) disable iff (reset || flush)
		valid_out && !ready_in |=> valid_out)
		else $error("valid_out dropped before ready_in");

	payload_held: assert property (@(posedge clk) disable iff (reset || flush)
		valid_out && !ready_in |=> $stable(result) && $stable(flags))
		else $error("result or flags changed while stalled");

	busy_after_accept: assert property (@(posedge clk) disable iff (reset || flush)
		valid_in && ready_out |=> !ready_out)
		else $error("ready_out high right after an accept");

	// Stays busy until the result leaves
	busy_in_flight: assert property (@(posedge clk) disable iff (reset || flush)
		!ready_out && !(valid_out && ready_in) |=> !ready_out)
		else $error("ready_out rose while an operation was in flight");

endmodule

`default_nettype wire

/* tests/fpu_tb.sv */
`default_nettype none

module fpu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fpu_pkg::*;

	localparam logic [31:0] seed = 32'ha02c_0eb7;
	localparam int n_addsub = 20;
	localparam int n_mul = 10;
	localparam int n_fused = 5;
	localparam int n_stall = 8;
	localparam int n_ops = n_addsub + n_mul + 1 + 4 * n_fused + 4 + n_stall + 2;
	localparam int reset_cycles = 8;
	localparam int cycle_limit = 40 * n_ops + reset_cycles;

	logic        clk;
	logic        reset;
	logic        flush;
	logic        valid_in;
	logic        ready_out;
	fp_op_t      op;
	fp_rm_t      rm;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic        valid_out;
	logic        ready_in;
	logic [31:0] result;
	fp_flags_t   flags;

	logic [31:0] rng;
	fp_resp_t    exp_q[$];
	fp_resp_t    exp_front;
	logic        exp_avail;
	logic        fire;
	int          cycles;

	fpu DUT (.*);

	bind fpu fpu_properties props (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("tests failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
		fail_run("output value differs from the expected one");
	endtask

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Nonzero so a zero product never turns into -0
	function automatic int rand_int();
		logic [31:0] x;
		int          v;
		v = 0;
		while (v == 0) begin
			x = next_rand();
			v = int'(x % 32'd2001) - 1000;
		end
		return v;
	endfunction

	function automatic logic [31:0] int_to_float(input int v);
		logic [31:0] mag;
		logic [31:0] frac;
		int          p;
		if (v == 0)
			return 32'd0;
		mag = (v < 0) ? -v : v;
		p = 0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i])
				p = i;
		end
		frac = mag << (23 - p);
		return {v < 0, 8'(127 + p), frac[22:0]};
	endfunction

	task automatic refresh_front();
		exp_avail = (exp_q.size() != 0);
		if (exp_avail)
			exp_front = exp_q[0];
	endtask

	task automatic send_op(input fp_op_t o, input fp_rm_t r, input logic [31:0] xa,
			input logic [31:0] xb, input logic [31:0] xc, input logic [31:0] want,
			input fp_flags_t want_flags);
		logic accepted;
		op = o;
		rm = r;
		a = xa;
		b = xb;
		c = xc;
		valid_in = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = ready_out;
			@(posedge clk);
		end
		exp_q.push_back('{result: want, flags: want_flags});
		refresh_front();
		#2 valid_in = 1'b0;
	endtask

	task automatic wait_result(input bit stall);
		logic [31:0] r;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
			r = next_rand();
			ready_in = stall ? r[0] : 1'b1;
		end
		ready_in = 1'b1;
	endtask

	// Handshake seen at the negedge lands on the next rising edge
	always @(negedge clk)
		fire = valid_out && ready_in;

	always @(posedge clk) begin
		if (fire && exp_q.size() != 0) begin
			exp_q.delete(0);
			refresh_front();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			fail_run("timeout, the run did not finish within the cycle limit");
	end

	out_expected: assert property (@(posedge clk) disable iff (reset)
		valid_out && ready_in |-> exp_avail)
		else fail_run("result left with no operation expected");

	result_check: assert property (@(posedge clk) disable iff (reset)
		valid_out && ready_in && exp_avail |-> result == exp_front.result)
		else report_mismatch("result", $sampled(result), $sampled(exp_front.result));

	flags_check: assert property (@(posedge clk) disable iff (reset)
		valid_out && ready_in && exp_avail |-> flags == exp_front.flags)
		else report_mismatch("flags", 32'($sampled(flags)), 32'($sampled(exp_front.flags)));

	initial begin
		int x;
		int y;
		int z;
		int p;
		int want;
		rng = seed;
		cycles = 0;
		fire = 1'b0;
		exp_avail = 1'b0;
		exp_front = '0;
		reset = 1'b1;
		flush = 1'b0;
		valid_in = 1'b0;
		op = op_nop;
		rm = rm_rne;
		a = '0;
		b = '0;
		c = '0;
		ready_in = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2 reset = 1'b0;

		for (int i = 0; i < n_addsub; i++) begin
			x = rand_int();
			y = rand_int();
			if (i % 2)
				send_op(op_sub, rm_rne, int_to_float(x), int_to_float(y), 0,
					int_to_float(x - y), '0);
			else
				send_op(op_add, rm_rne, int_to_float(x), int_to_float(y), 0,
					int_to_float(x + y), '0);
			wait_result(1'b0);
		end

		for (int i = 0; i < n_mul; i++) begin
			x = rand_int();
			y = rand_int();
			send_op(op_mul, rm_rtz, int_to_float(x), int_to_float(y), 0,
				int_to_float(x * y), '0);
			wait_result(1'b0);
		end
		send_op(op_mul, rm_rne, 32'd0, int_to_float(5), 0, 32'd0, '0);
		wait_result(1'b0);

		for (int i = 0; i < n_fused; i++) begin
			for (int k = 0; k < 4; k++) begin
				x = rand_int();
				y = rand_int();
				z = rand_int();
				p = x * y;
				case (k)
					0: want = p + z;
					1: want = p - z;
					2: want = -p + z;
					default: want = -p - z;
				endcase
				send_op(fp_op_t'(3'(4 + k)), rm_rne, int_to_float(x), int_to_float(y),
					int_to_float(z), int_to_float(want), '0);
				wait_result(1'b0);
			end
		end

		// Invalid, overflow under both rounding modes
		send_op(op_sub, rm_rne, 32'h7f80_0000, 32'h7f80_0000, 0, fp_canon_nan, 4'b1000);
		wait_result(1'b0);
		send_op(op_mul, rm_rne, 32'd0, 32'h7f80_0000, 0, fp_canon_nan, 4'b1000);
		wait_result(1'b0);
		send_op(op_mul, rm_rne, 32'h7180_0000, 32'h7180_0000, 0, 32'h7f80_0000, 4'b0101);
		wait_result(1'b0);
		send_op(op_mul, rm_rtz, 32'h7180_0000, 32'h7180_0000, 0, 32'h7f7f_ffff, 4'b0101);
		wait_result(1'b0);

		for (int i = 0; i < n_stall; i++) begin
			x = rand_int();
			y = rand_int();
			send_op(op_add, rm_rne, int_to_float(x), int_to_float(y), 0,
				int_to_float(x + y), '0);
			wait_result(1'b1);
		end

		// Flushed madd must never produce an output
		send_op(op_madd, rm_rne, int_to_float(3), int_to_float(4), int_to_float(5),
			int_to_float(17), '0);
		repeat (2) @(posedge clk);
		#2 flush = 1'b1;
		@(posedge clk);
		#2 flush = 1'b0;
		exp_q.delete();
		refresh_front();
		repeat (8) @(posedge clk);
		#2;
		send_op(op_nmadd, rm_rne, int_to_float(6), int_to_float(7), int_to_float(8),
			int_to_float(-50), '0);
		wait_result(1'b0);

		repeat (4) @(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* fpu_unit.f */
verilog/fpu_pkg.sv
verilog/fp_stage_reg.sv
verilog/fp_addsub.sv
verilog/fp_mul.sv
verilog/fpu_core.sv
verilog/fpu.sv
tests/fpu_properties.sv
tests/fpu_tb.sv

/* run.sh */
#!/bin/sh
# Builds with Verilator and runs; the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f fpu_unit.f --top-module fpu_tb -o fpu_sim &&
./obj_dir/fpu_sim || exit 1
